/* common/fetch_pkg.sv */
package fetch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sizes and timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int ADDR_W      = 32;
	localparam int DATA_W      = 32;
	localparam int NUM_REQS    = 2; // max fetches in flight
	localparam int FIFO_DEPTH  = 3; // NUM_REQS plus one slot of slack
	localparam int MEM_WORDS   = 64;
	localparam int MEM_LATENCY = 2; // grant to rvalid

	// non-executable byte window, upper bound exclusive
	localparam logic [ADDR_W-1:0] NX_BASE  = ADDR_W'(8'hC0);
	localparam logic [ADDR_W-1:0] NX_LIMIT = ADDR_W'(9'h100);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus and entry types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr; // word aligned
	} fetch_req_t;

	typedef struct packed {
		logic              gnt;
		logic              rvalid;
		logic [DATA_W-1:0] rdata;
		logic              err;     // out of range, with rvalid
		logic              pmp_err; // replaces gnt
	} fetch_rsp_t;

	typedef struct packed {
		logic [DATA_W-1:0] instr;
		logic [ADDR_W-1:0] addr;
		logic              err;
	} fetch_entry_t;

endpackage

/* prefetch/fetch_fifo.sv */
module fetch_fifo (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         clear_i,
	input  logic [fetch_pkg::ADDR_W-1:0] clear_addr_i,
	input  logic                         in_valid_i,
	input  logic [fetch_pkg::DATA_W-1:0] in_rdata_i,
	input  logic                         in_err_i,
	output logic                         in_ready_o,
	output logic                         out_valid_o,
	input  logic                         out_ready_i,
	output fetch_pkg::fetch_entry_t      out_entry_o
);
	import fetch_pkg::*;

	logic [FIFO_DEPTH-1:0] valid_q;
	logic [FIFO_DEPTH-1:0] valid_pushed;
	logic [FIFO_DEPTH-1:0] valid_d;
	logic [FIFO_DEPTH-1:0] push_slot;
	logic [DATA_W-1:0]     rdata_q [FIFO_DEPTH];
	logic [DATA_W-1:0]     rdata_d [FIFO_DEPTH];
	logic                  err_q   [FIFO_DEPTH];
	logic                  err_d   [FIFO_DEPTH];
	logic [ADDR_W-1:0]     addr_q;
	logic                  pop;

	assign pop = valid_q[0] & out_ready_i;

	// entries packed from index 0, head is always slot 0
	assign push_slot = in_valid_i ? ((valid_q + 1'b1) & ~valid_q) : '0;
	assign valid_pushed = valid_q | push_slot;
	assign valid_d = clear_i ? '0 : (pop ? (valid_pushed >> 1) : valid_pushed);

	// room for every response that may still be in flight, plus the next one
	assign in_ready_o = pop ? ~valid_q[FIFO_DEPTH-NUM_REQS] :
		~valid_q[FIFO_DEPTH-NUM_REQS-1];

	always_comb begin
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			rdata_d[i] = push_slot[i] ? in_rdata_i : rdata_q[i];
			err_d[i] = push_slot[i] ? in_err_i : err_q[i];
		end
		if (pop) begin
			for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
				rdata_d[i] = rdata_d[i+1]; // ascending, so reads the pushed value
				err_d[i] = err_d[i+1];
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_d;
		end
	end

	always_ff @(posedge clk_i) begin
		rdata_q <= rdata_d;
		err_q <= err_d;
	end

	// head address follows the pops, entries carry none
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			addr_q <= '0;
		end else if (clear_i) begin
			addr_q <= {clear_addr_i[ADDR_W-1:2], 2'b00};
		end else if (pop) begin
			addr_q <= addr_q + ADDR_W'(4);
		end
	end

	assign out_valid_o = valid_q[0];
	assign out_entry_o.instr = rdata_q[0];
	assign out_entry_o.addr = addr_q;
	assign out_entry_o.err = err_q[0];

endmodule

/* prefetch/prefetch_buffer.sv */
module prefetch_buffer (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         req_i,
	input  logic                         branch_i,
	input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
	input  logic                         ready_i,
	output logic                         valid_o,
	output fetch_pkg::fetch_entry_t      entry_o,
	output fetch_pkg::fetch_req_t        mem_req_o,
	input  fetch_pkg::fetch_rsp_t        mem_rsp_i,
	output logic                         busy_o
);
	import fetch_pkg::*;

	logic                valid_new_req;
	logic                new_fetch;
	logic                valid_req;
	logic                valid_req_q;
	logic                discard_req_d;
	logic                discard_req_q;
	logic                accept;
	logic                rsp_done;
	logic                slot_free;
	logic [NUM_REQS-1:0] outstanding_q;
	logic [NUM_REQS-1:0] outstanding_s;
	logic [NUM_REQS-1:0] discard_q;
	logic [NUM_REQS-1:0] discard_s;
	logic [NUM_REQS-1:0] discard_d;
	logic [NUM_REQS-1:0] pmp_err_q;
	logic [NUM_REQS-1:0] pmp_err_s;
	logic [NUM_REQS-1:0] new_slot;
	logic [ADDR_W-1:0]   branch_addr_w;
	logic [ADDR_W-1:0]   fetch_addr_q;
	logic [ADDR_W-1:0]   fetch_addr_d;
	logic [ADDR_W-1:0]   stored_addr_q;
	logic [ADDR_W-1:0]   req_addr;
	logic                fifo_push;
	logic                fifo_err;
	logic [DATA_W-1:0]   fifo_rdata;
	logic                fifo_ready;

	assign branch_addr_w = {branch_addr_i[ADDR_W-1:2], 2'b00};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// oldest slot retires on rvalid, or at once for a pmp error
	assign rsp_done = outstanding_q[0] & (mem_rsp_i.rvalid | pmp_err_q[0]);
	assign slot_free = ~outstanding_q[NUM_REQS-1] | rsp_done; // retiring slot can be reused

	assign valid_new_req = req_i & (fifo_ready | branch_i) & slot_free;
	assign new_fetch = valid_new_req & ~valid_req_q;
	assign valid_req = valid_req_q | valid_new_req;
	assign accept = valid_req & (mem_rsp_i.gnt | mem_rsp_i.pmp_err);

	// a waiting request that sees a branch is fetched but thrown away
	assign discard_req_d = valid_req_q & (branch_i | discard_req_q);

	assign req_addr = valid_req_q ? stored_addr_q :
		(branch_i ? branch_addr_w : fetch_addr_q);

	assign fetch_addr_d = (branch_i ? branch_addr_w : fetch_addr_q) +
		(new_fetch ? ADDR_W'(4) : ADDR_W'(0));

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			fetch_addr_q <= '0;
		end else if (branch_i | new_fetch) begin
			fetch_addr_q <= fetch_addr_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (new_fetch & ~accept) begin
			stored_addr_q <= req_addr; // hold until granted
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// outstanding slots
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign outstanding_s = rsp_done ? (outstanding_q >> 1) : outstanding_q;
	assign discard_s = rsp_done ? (discard_q >> 1) : discard_q;
	assign pmp_err_s = rsp_done ? (pmp_err_q >> 1) : pmp_err_q;

	// lowest empty slot of the thermometer
	assign new_slot = accept ? ((outstanding_s + 1'b1) & ~outstanding_s) : '0;

	assign discard_d = discard_s | (branch_i ? outstanding_s : '0) |
		(discard_req_d ? new_slot : '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_req_q <= 1'b0;
			discard_req_q <= 1'b0;
			outstanding_q <= '0;
			discard_q <= '0;
			pmp_err_q <= '0;
		end else begin
			valid_req_q <= valid_req & ~accept;
			discard_req_q <= discard_req_d;
			outstanding_q <= outstanding_s | new_slot;
			discard_q <= discard_d;
			pmp_err_q <= pmp_err_s | (mem_rsp_i.pmp_err ? new_slot : '0);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// response side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign fifo_push = rsp_done & ~discard_q[0];
	assign fifo_err = mem_rsp_i.err | pmp_err_q[0];
	assign fifo_rdata = pmp_err_q[0] ? '0 : mem_rsp_i.rdata; // no memory data on pmp

	fetch_fifo u_fifo (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.clear_i      (branch_i),
		.clear_addr_i (branch_addr_i),
		.in_valid_i   (fifo_push),
		.in_rdata_i   (fifo_rdata),
		.in_err_i     (fifo_err),
		.in_ready_o   (fifo_ready),
		.out_valid_o  (valid_o),
		.out_ready_i  (ready_i),
		.out_entry_o  (entry_o)
	);

	assign mem_req_o.valid = valid_req;
	assign mem_req_o.addr = req_addr;

	assign busy_o = (|outstanding_q) | valid_req;

endmodule

/* design/instr_mem.sv */
module instr_mem (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  fetch_pkg::fetch_req_t mem_req_i,
	output fetch_pkg::fetch_rsp_t mem_rsp_o
);
	import fetch_pkg::*;

	logic [DATA_W-1:0]      mem [MEM_WORDS];
	logic                   nx_hit;
	logic                   range_err;
	logic                   gnt;
	logic [DATA_W-1:0]      rd_word;
	logic [MEM_LATENCY-1:0] vld_q;
	logic [DATA_W-1:0]      rdata_q [MEM_LATENCY];
	logic                   err_q   [MEM_LATENCY];

	initial begin
		$readmemh("imem.hex", mem);
	end

	// execute check on the byte address of the request
	assign nx_hit = (mem_req_i.addr >= NX_BASE) && (mem_req_i.addr < NX_LIMIT);
	assign range_err = mem_req_i.addr >= ADDR_W'(MEM_WORDS * 4);

	assign gnt = mem_req_i.valid & ~nx_hit; // nx requests never reach the array

	assign rd_word = range_err ? '0 :
		mem[mem_req_i.addr[$clog2(MEM_WORDS)+1:2]];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fixed latency response pipe
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			vld_q <= '0;
		end else begin
			vld_q <= (vld_q << 1) | MEM_LATENCY'(gnt);
		end
	end

	always_ff @(posedge clk_i) begin
		rdata_q[0] <= rd_word;
		err_q[0] <= range_err;
		for (int i = 1; i < MEM_LATENCY; i++) begin
			rdata_q[i] <= rdata_q[i-1];
			err_q[i] <= err_q[i-1];
		end
	end

	assign mem_rsp_o.gnt = gnt;
	assign mem_rsp_o.rvalid = vld_q[MEM_LATENCY-1];
	assign mem_rsp_o.rdata = rdata_q[MEM_LATENCY-1];
	assign mem_rsp_o.err = vld_q[MEM_LATENCY-1] & err_q[MEM_LATENCY-1]; // only with rvalid
	assign mem_rsp_o.pmp_err = mem_req_i.valid & nx_hit;

endmodule

/* design/fetch_top.sv */
module fetch_top (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         req_i,
	input  logic                         branch_i,
	input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
	input  logic                         ready_i,
	output logic                         valid_o,
	output fetch_pkg::fetch_entry_t      entry_o,
	output logic                         busy_o
);
	import fetch_pkg::*;

	fetch_req_t mem_req; // prefetch to memory
	fetch_rsp_t mem_rsp; // memory to prefetch

	prefetch_buffer u_prefetch (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.req_i         (req_i),
		.branch_i      (branch_i),
		.branch_addr_i (branch_addr_i),
		.ready_i       (ready_i),
		.valid_o       (valid_o),
		.entry_o       (entry_o),
		.mem_req_o     (mem_req),
		.mem_rsp_i     (mem_rsp),
		.busy_o        (busy_o)
	);

	instr_mem u_imem (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.mem_req_i (mem_req),
		.mem_rsp_o (mem_rsp)
	);

endmodule

/* dv/fetch_properties.sv */
module fetch_properties (
	input logic                             clk_i,
	input logic                             rst_ni,
	input logic                             branch_i,
	input logic                             ready_i,
	input logic                             out_valid_i,
	input fetch_pkg::fetch_entry_t          out_entry_i,
	input fetch_pkg::fetch_req_t            mem_req_i,
	input fetch_pkg::fetch_rsp_t            mem_rsp_i,
	input logic [fetch_pkg::NUM_REQS-1:0]   outstanding_i,
	input logic                             rsp_done_i
);
	int   fail_cnt = 0;
	logic accept;

	assign accept = mem_req_i.valid & (mem_rsp_i.gnt | mem_rsp_i.pmp_err);

	// waiting request keeps its address until granted
	req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		mem_req_i.valid && !accept |=> mem_req_i.valid && $stable(mem_req_i.addr))
	else begin
		$error("memory request changed while waiting for grant");
		fail_cnt++;
	end

	// all slots busy and none retiring, so no new accept
	max_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(&outstanding_i) && !rsp_done_i |-> !accept)
	else begin
		$error("more fetches outstanding than slots");
		fail_cnt++;
	end

	entry_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_valid_i && !ready_i && !branch_i |=> out_valid_i && $stable(out_entry_i))
	else begin
		$error("output entry changed while stalled");
		fail_cnt++;
	end

endmodule

bind prefetch_buffer fetch_properties u_props (
	.clk_i         (clk_i),
	.rst_ni        (rst_ni),
	.branch_i      (branch_i),
	.ready_i       (ready_i),
	.out_valid_i   (valid_o),
	.out_entry_i   (entry_o),
	.mem_req_i     (mem_req_o),
	.mem_rsp_i     (mem_rsp_i),
	.outstanding_i (outstanding_q),
	.rsp_done_i    (rsp_done)
);

/* dv/fetch_tb.sv */
module fetch_tb;
	import fetch_pkg::*;

	localparam int NUM_TESTS      = 6;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 400; // 400 cycles per test

	logic              clk_i;
	logic              rst_ni;
	logic              req_i;
	logic              branch_i;
	logic [ADDR_W-1:0] branch_addr_i;
	logic              ready_i;
	logic              valid_o;
	fetch_entry_t      entry_o;
	logic              busy_o;

	logic [DATA_W-1:0] ref_mem [MEM_WORDS];
	logic [ADDR_W-1:0] exp_addr; // next address decode should see
	logic              busy_seen;
	int                taken;
	int                cycles;

	fetch_top dut (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.req_i         (req_i),
		.branch_i      (branch_i),
		.branch_addr_i (branch_addr_i),
		.ready_i       (ready_i),
		.valid_o       (valid_o),
		.entry_o       (entry_o),
		.busy_o        (busy_o)
	);

	always #5 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the fetch unit stopped delivering", cycles);
			$display("Verification failed");
			$fatal(1);
		end
	end

	always @(negedge clk_i) begin
		if (dut.u_prefetch.u_props.fail_cnt != 0) begin
			$display("a bus or output rule assertion failed");
			$display("Verification failed");
			$fatal(1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic fetch_entry_t ref_entry(input logic [ADDR_W-1:0] addr);
		fetch_entry_t e;
		e.addr = addr;
		e.err = (addr >= NX_BASE && addr < NX_LIMIT) || addr >= ADDR_W'(MEM_WORDS * 4);
		if (e.err) begin
			e.instr = '0; // no data on error entries
		end else begin
			e.instr = ref_mem[addr[$clog2(MEM_WORDS)+1:2]];
		end
		return e;
	endfunction

	task automatic entry_check(input string test, input fetch_entry_t exp,
		input fetch_entry_t act);
		if (act.addr !== exp.addr || act.err !== exp.err ||
			(!exp.err && act.instr !== exp.instr)) begin
			$display("Fail %s: expected addr %h instr %h err %b, actual addr %h instr %h err %b",
				test, exp.addr, exp.instr, exp.err, act.addr, act.instr, act.err);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic flag_check(input string test, input string what, input logic exp,
		input logic act);
		if (act !== exp) begin
			$display("Fail %s: %s expected %b, actual %b", test, what, exp, act);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// one cycle with outputs taken at the falling edge before new inputs
	task automatic clock_step(input string test, input logic rdy);
		@(negedge clk_i);
		busy_seen = busy_o;
		branch_i = 1'b0;
		ready_i = rdy;
		if (valid_o && rdy) begin
			entry_check(test, ref_entry(exp_addr), entry_o);
			exp_addr = exp_addr + ADDR_W'(4);
			taken++;
		end
	endtask

	task automatic take_entries(input string test, input int n, input int ready_pct);
		int stop_at;
		stop_at = taken + n;
		while (taken < stop_at) begin
			clock_step(test, ($urandom % 100) < ready_pct);
		end
	endtask

	task automatic branch_to(input logic [ADDR_W-1:0] target);
		@(negedge clk_i);
		req_i = 1'b1;
		branch_i = 1'b1;
		branch_addr_i = target;
		exp_addr = {target[ADDR_W-1:2], 2'b00};
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic sequential_fetch();
		branch_to(32'h0);
		clock_step("sequential", 1'b0);
		flag_check("sequential", "valid_o", 1'b0, valid_o);
		clock_step("sequential", 1'b0);
		flag_check("sequential", "valid_o", 1'b0, valid_o);
		clock_step("sequential", 1'b0);
		flag_check("sequential", "valid_o", 1'b1, valid_o); // third cycle after branch
		take_entries("sequential", 16, 100);
	endtask

	task automatic branch_redirect();
		branch_to(32'h40);
		take_entries("redirect", 5, 100);
		branch_to(32'h46); // unaligned target
		take_entries("redirect", 6, 100);
		branch_to(32'h10);
		branch_to(32'h88);
		take_entries("redirect", 4, 100);
		repeat (6) clock_step("redirect", 1'b0);
		branch_to(32'h30);
		take_entries("redirect", 5, 100);
	endtask

	task automatic back_pressure();
		branch_to(32'h20);
		take_entries("back_pressure", 24, 30);
		repeat (8) clock_step("back_pressure", 1'b0);
		flag_check("back_pressure", "busy_o", 1'b0, busy_seen); // fifo full so fetch has stopped
		flag_check("back_pressure", "valid_o", 1'b1, valid_o);
		take_entries("back_pressure", 12, 50);
	endtask

	task automatic protection_error();
		branch_to(32'hB4);
		take_entries("protection", 8, 100);
	endtask

	task automatic range_error();
		branch_to(32'hF8);
		take_entries("range", 4, 100);
		branch_to(32'h1F2);
		take_entries("range", 3, 100);
	endtask

	task automatic idle_drain();
		branch_to(32'h60);
		take_entries("idle", 4, 100);
		req_i = 1'b0;
		clock_step("idle", 1'b1);
		while (busy_seen || valid_o) begin
			clock_step("idle", 1'b1);
		end
		repeat (5) clock_step("idle", 1'b1);
		flag_check("idle", "busy_o", 1'b0, busy_seen);
		flag_check("idle", "valid_o", 1'b0, valid_o);
	endtask

	initial begin
		clk_i = 1'b0;
		rst_ni = 1'b0;
		req_i = 1'b0;
		branch_i = 1'b0;
		branch_addr_i = '0;
		ready_i = 1'b0;
		exp_addr = '0;
		busy_seen = 1'b0;
		taken = 0;
		cycles = 0;
		void'($urandom(32'h5c4b_7ed4));
		$readmemh("imem.hex", ref_mem);
		repeat (8) @(negedge clk_i);
		rst_ni = 1'b1;
		clock_step("reset", 1'b0);
		flag_check("reset", "valid_o", 1'b0, valid_o);
		flag_check("reset", "busy_o", 1'b0, busy_seen);
		sequential_fetch();
		branch_redirect();
		back_pressure();
		protection_error();
		range_error();
		idle_drain();
		if (dut.u_prefetch.u_props.fail_cnt == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("%0d bus or output rule violations", dut.u_prefetch.u_props.fail_cnt);
			$display("Verification failed");
			$fatal(1);
		end
	end

endmodule

/* project.f */
common/fetch_pkg.sv
prefetch/fetch_fifo.sv
prefetch/prefetch_buffer.sv
design/instr_mem.sv
design/fetch_top.sv
dv/fetch_properties.sv
dv/fetch_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide pass or fail from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
	-f project.f -o fetch_sim || { echo "build failed"; exit 1; }
./obj_dir/fetch_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* imem.hex */
// one 32-bit instruction word per line, word 0 first
// word layout A5, word index (2 hex digits), byte address (4 hex digits)
A5000000
A5010004
A5020008
A503000C
A5040010
A5050014
A5060018
A507001C
A5080020
A5090024
A50A0028
A50B002C
A50C0030
A50D0034
A50E0038
A50F003C
A5100040
A5110044
A5120048
A513004C
A5140050
A5150054
A5160058
A517005C
A5180060
A5190064
A51A0068
A51B006C
A51C0070
A51D0074
A51E0078
A51F007C
A5200080
A5210084
A5220088
A523008C
A5240090
A5250094
A5260098
A527009C
A52800A0
A52900A4
A52A00A8
A52B00AC
A52C00B0
A52D00B4
A52E00B8
A52F00BC
A53000C0
A53100C4
A53200C8
A53300CC
A53400D0
A53500D4
A53600D8
A53700DC
A53800E0
A53900E4
A53A00E8
A53B00EC
A53C00F0
A53D00F4
A53E00F8
A53F00FC
